//--- hdl/ntm_params.svh
`ifndef NTM_PARAMS_SVH
`define NTM_PARAMS_SVH

// Memory matrix geometry
// Rows N
`define NTM_ROWS 8
// Columns W
`define NTM_COLS 4

// Index widths for row and column counters
`define NTM_ROW_W 3
`define NTM_COL_W 2

// Q8.8 signed word format
`define NTM_DATA_W 16
// Fraction bits of a word
`define NTM_FRAC 8

`endif

//--- hdl/ntm_pkg.sv
`default_nettype none

`include "ntm_params.svh"

package ntm_pkg;

  // Signed Q8.8 memory and vector word
  typedef logic signed [`NTM_DATA_W-1:0] ntm_word_t;

  // Target vector of a host load strobe
  typedef enum logic [1:0] {
    VEC_READ_WEIGHT,
    VEC_WRITE_WEIGHT,
    VEC_ERASE,
    VEC_ADD
  } ntm_vec_sel_e;

  // Write head opcodes
  typedef enum logic [1:0] {
    OP_ERASE,
    OP_ADD,
    OP_ERASE_ADD
  } ntm_write_op_e;

  // One access to the shared memory port
  typedef struct packed {
    logic                  write;
    logic [`NTM_ROW_W-1:0] row;
    logic [`NTM_COL_W-1:0] col;
    ntm_word_t             data;
  } ntm_mem_req_t;

  // Host load word, index covers the longer vector
  typedef struct packed {
    ntm_vec_sel_e          sel;
    logic [`NTM_ROW_W-1:0] index;
    ntm_word_t             data;
  } ntm_load_t;

  // Q8.8 product, full width then rescaled and truncated
  function automatic ntm_word_t ntm_fxp_mul(input ntm_word_t a, input ntm_word_t b);
    logic signed [2*`NTM_DATA_W-1:0] prod;
    logic signed [2*`NTM_DATA_W-1:0] scaled;
    prod   = a * b;
    scaled = prod >>> `NTM_FRAC;
    return scaled[`NTM_DATA_W-1:0];
  endfunction

endpackage

`default_nettype wire

//--- hdl/ntm_head_vectors.sv
`timescale 1ns/1ns
`default_nettype none

`include "ntm_params.svh"

module ntm_head_vectors (
  input  wire logic                CLK,
  input  wire logic                RST,
  // Host load strobe
  input  wire logic                load_enable,
  input  wire ntm_pkg::ntm_load_t  load,
  // Vectors seen by the heads
  output ntm_pkg::ntm_word_t       read_weight  [`NTM_ROWS],
  output ntm_pkg::ntm_word_t       write_weight [`NTM_ROWS],
  output ntm_pkg::ntm_word_t       erase_vec    [`NTM_COLS],
  output ntm_pkg::ntm_word_t       add_vec      [`NTM_COLS]
);

  import ntm_pkg::*;

  // Erase and add vectors are only W long
  logic col_index_ok;

  assign col_index_ok = (load.index < `NTM_ROW_W'(`NTM_COLS));

  ////////////////////////////////////////////////////////////////////////////
  // Vector registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int j = 0; j < `NTM_ROWS; j++) begin
        read_weight[j]  <= '0;
        write_weight[j] <= '0;
      end
      for (int k = 0; k < `NTM_COLS; k++) begin
        erase_vec[k] <= '0;
        add_vec[k]   <= '0;
      end
    end else if (load_enable) begin
      // One element per strobe
      case (load.sel)
        VEC_READ_WEIGHT:  read_weight[load.index]  <= load.data;
        VEC_WRITE_WEIGHT: write_weight[load.index] <= load.data;
        VEC_ERASE: begin
          if (col_index_ok) begin
            erase_vec[load.index[`NTM_COL_W-1:0]] <= load.data;
          end
        end
        default: begin
          // Add vector
          if (col_index_ok) begin
            add_vec[load.index[`NTM_COL_W-1:0]] <= load.data;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/ntm_read_head.sv
`timescale 1ns/1ns
`default_nettype none

`include "ntm_params.svh"

module ntm_read_head (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  start,
  input  wire ntm_pkg::ntm_word_t    weight [`NTM_ROWS],
  // Memory port through the arbiter
  output logic                       mem_req,
  output ntm_pkg::ntm_mem_req_t      mem_req_data,
  input  wire logic                  mem_gnt,
  input  wire ntm_pkg::ntm_word_t    mem_rdata,
  // Read vector, one word per column
  output logic                       r_out_enable,
  output ntm_pkg::ntm_word_t         r_out,
  output logic                       ready
);

  import ntm_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    REQUEST,
    WAIT_DATA,
    EMIT,
    DONE
  } state_e;

  state_e                state;
  logic [`NTM_ROW_W-1:0] row;
  logic [`NTM_COL_W-1:0] col;
  // Running sum for the current column
  ntm_word_t             acc;
  // w(j) times M(j,k) for the returned word
  ntm_word_t             prod;

  assign prod = ntm_fxp_mul(weight[row], mem_rdata);

  ////////////////////////////////////////////////////////////////////////////
  // Column and row walk
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
      row   <= '0;
      col   <= '0;
      acc   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            row   <= '0;
            col   <= '0;
            acc   <= '0;
            state <= REQUEST;
          end
        end
        // Hold the request until granted
        REQUEST: begin
          if (mem_gnt) begin
            state <= WAIT_DATA;
          end
        end
        // Registered read data arrives here
        WAIT_DATA: begin
          acc <= acc + prod;
          if (row == `NTM_ROW_W'(`NTM_ROWS - 1)) begin
            state <= EMIT;
          end else begin
            row   <= row + 1'b1;
            state <= REQUEST;
          end
        end
        // r(k) on the output for this cycle
        EMIT: begin
          row <= '0;
          acc <= '0;
          if (col == `NTM_COL_W'(`NTM_COLS - 1)) begin
            state <= DONE;
          end else begin
            col   <= col + 1'b1;
            state <= REQUEST;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Reads only, data field unused
  assign mem_req      = (state == REQUEST);
  assign mem_req_data = '{write: 1'b0, row: row, col: col, data: '0};

  // Strobes decoded from state
  assign r_out_enable = (state == EMIT);
  assign r_out        = acc;
  assign ready        = (state == DONE);

endmodule

`default_nettype wire

//--- hdl/ntm_write_head.sv
`timescale 1ns/1ns
`default_nettype none

`include "ntm_params.svh"

module ntm_write_head (
  input  wire logic                   CLK,
  input  wire logic                   RST,
  input  wire logic                   start,
  input  wire ntm_pkg::ntm_write_op_e op,
  // Write weighting, erase and add vectors
  input  wire ntm_pkg::ntm_word_t     weight    [`NTM_ROWS],
  input  wire ntm_pkg::ntm_word_t     erase_vec [`NTM_COLS],
  input  wire ntm_pkg::ntm_word_t     add_vec   [`NTM_COLS],
  // Memory port through the arbiter
  output logic                        mem_req,
  output ntm_pkg::ntm_mem_req_t       mem_req_data,
  input  wire logic                   mem_gnt,
  input  wire ntm_pkg::ntm_word_t     mem_rdata,
  output logic                        ready
);

  import ntm_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    READ_REQ,
    WAIT_DATA,
    WRITE_REQ,
    DONE
  } state_e;

  state_e                state;
  ntm_write_op_e         op_q;
  logic [`NTM_ROW_W-1:0] row;
  logic [`NTM_COL_W-1:0] col;
  logic                  last_word;
  // Word waiting to be written back
  ntm_word_t             wdata;

  // Update terms for the current word
  ntm_word_t             cur_weight;
  ntm_word_t             we_prod;
  ntm_word_t             erased;
  ntm_word_t             add_term;
  ntm_word_t             new_word;

  ////////////////////////////////////////////////////////////////////////////
  // Erase and add datapath
  ////////////////////////////////////////////////////////////////////////////

  assign cur_weight = weight[row];
  assign we_prod    = ntm_fxp_mul(cur_weight, erase_vec[col]);
  // M times (1 - w*e), ONE is 1.0 in Q8.8
  assign erased     = ntm_fxp_mul(mem_rdata, ntm_word_t'(1 << `NTM_FRAC) - we_prod);
  assign add_term   = ntm_fxp_mul(cur_weight, add_vec[col]);

  always_comb begin
    case (op_q)
      OP_ERASE: new_word = erased;
      OP_ADD:   new_word = mem_rdata + add_term;
      // Erase first, then add on the erased word
      default:  new_word = erased + add_term;
    endcase
  end

  assign last_word = (row == `NTM_ROW_W'(`NTM_ROWS - 1)) &&
                     (col == `NTM_COL_W'(`NTM_COLS - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Read-modify-write sequencer, row-major order
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
      op_q  <= OP_ERASE;
      row   <= '0;
      col   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            op_q  <= op;
            row   <= '0;
            col   <= '0;
            state <= READ_REQ;
          end
        end
        READ_REQ: begin
          if (mem_gnt) begin
            state <= WAIT_DATA;
          end
        end
        WAIT_DATA: state <= WRITE_REQ;
        // Write back, then step to the next word
        WRITE_REQ: begin
          if (mem_gnt) begin
            if (last_word) begin
              state <= DONE;
            end else begin
              if (col == `NTM_COL_W'(`NTM_COLS - 1)) begin
                row <= row + 1'b1;
              end
              col   <= col + 1'b1;
              state <= READ_REQ;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Capture the updated word with the read data
  always_ff @(posedge CLK) begin
    if (state == WAIT_DATA) begin
      wdata <= new_word;
    end
  end

  assign mem_req      = (state == READ_REQ) || (state == WRITE_REQ);
  assign mem_req_data = '{write: (state == WRITE_REQ), row: row, col: col, data: wdata};
  assign ready        = (state == DONE);

endmodule

`default_nettype wire

//--- hdl/ntm_mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module ntm_mem_arbiter (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  // Read head side
  input  wire logic                  read_req,
  input  wire ntm_pkg::ntm_mem_req_t read_req_data,
  output logic                       read_gnt,
  // Write head side
  input  wire logic                  write_req,
  input  wire ntm_pkg::ntm_mem_req_t write_req_data,
  output logic                       write_gnt,
  // Memory side
  output logic                       mem_strobe,
  output ntm_pkg::ntm_mem_req_t      mem_req_data,
  input  wire ntm_pkg::ntm_word_t    mem_rdata_in,
  output ntm_pkg::ntm_word_t         mem_rdata
);

  // High when the write head took the last access
  logic write_last;

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin grant
  ////////////////////////////////////////////////////////////////////////////

  // A lone requester always wins
  // On a tie the head not served last wins
  assign read_gnt  = read_req & (~write_req | write_last);
  assign write_gnt = write_req & (~read_req | ~write_last);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      write_last <= 1'b1;
    end else if (read_gnt | write_gnt) begin
      write_last <= write_gnt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request mux and read return
  ////////////////////////////////////////////////////////////////////////////

  assign mem_strobe   = read_gnt | write_gnt;
  assign mem_req_data = write_gnt ? write_req_data : read_req_data;

  // Both heads see the data
  // only the one waiting on it samples
  assign mem_rdata = mem_rdata_in;

endmodule

`default_nettype wire

//--- hdl/ntm_memory.sv
`timescale 1ns/1ns
`default_nettype none

`include "ntm_params.svh"

module ntm_memory (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  // Granted access
  input  wire logic                  strobe,
  input  wire ntm_pkg::ntm_mem_req_t req,
  output ntm_pkg::ntm_word_t         rdata
);

  import ntm_pkg::*;

  // M(j,k), rows by columns
  ntm_word_t mem [`NTM_ROWS][`NTM_COLS];

  // Writes land on the grant edge
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int j = 0; j < `NTM_ROWS; j++) begin
        for (int k = 0; k < `NTM_COLS; k++) begin
          mem[j][k] <= '0;
        end
      end
    end else if (strobe && req.write) begin
      mem[req.row][req.col] <= req.data;
    end
  end

  // Read data valid the cycle after the grant
  always_ff @(posedge CLK) begin
    if (strobe && !req.write) begin
      rdata <= mem[req.row][req.col];
    end
  end

endmodule

`default_nettype wire

//--- hdl/ntm_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "ntm_params.svh"

module ntm_top (
  input  wire logic                   CLK,
  input  wire logic                   RST,
  // Vector load
  input  wire logic                   LOAD_ENABLE,
  input  wire ntm_pkg::ntm_load_t     LOAD,
  // Read head
  input  wire logic                   READ_START,
  output logic                        READ_READY,
  output logic                        R_OUT_ENABLE,
  output ntm_pkg::ntm_word_t          R_OUT,
  // Write head
  input  wire logic                   WRITE_START,
  input  wire ntm_pkg::ntm_write_op_e WRITE_OP,
  output logic                        WRITE_READY
);

  import ntm_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////////////////////

  // Head vectors
  ntm_word_t    read_weight  [`NTM_ROWS];
  ntm_word_t    write_weight [`NTM_ROWS];
  ntm_word_t    erase_vec    [`NTM_COLS];
  ntm_word_t    add_vec      [`NTM_COLS];

  // Head to arbiter
  logic         read_req;
  logic         read_gnt;
  ntm_mem_req_t read_req_data;
  logic         write_req;
  logic         write_gnt;
  ntm_mem_req_t write_req_data;

  // Arbiter to memory and back
  logic         mem_strobe;
  ntm_mem_req_t mem_req_data;
  ntm_word_t    mem_rdata_raw;
  ntm_word_t    mem_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////////////

  ntm_head_vectors u_vectors (
    .CLK          (CLK),
    .RST          (RST),
    .load_enable  (LOAD_ENABLE),
    .load         (LOAD),
    .read_weight  (read_weight),
    .write_weight (write_weight),
    .erase_vec    (erase_vec),
    .add_vec      (add_vec)
  );

  ntm_read_head u_read_head (
    .CLK          (CLK),
    .RST          (RST),
    .start        (READ_START),
    .weight       (read_weight),
    .mem_req      (read_req),
    .mem_req_data (read_req_data),
    .mem_gnt      (read_gnt),
    .mem_rdata    (mem_rdata),
    .r_out_enable (R_OUT_ENABLE),
    .r_out        (R_OUT),
    .ready        (READ_READY)
  );

  ntm_write_head u_write_head (
    .CLK          (CLK),
    .RST          (RST),
    .start        (WRITE_START),
    .op           (WRITE_OP),
    .weight       (write_weight),
    .erase_vec    (erase_vec),
    .add_vec      (add_vec),
    .mem_req      (write_req),
    .mem_req_data (write_req_data),
    .mem_gnt      (write_gnt),
    .mem_rdata    (mem_rdata),
    .ready        (WRITE_READY)
  );

  // Single memory port shared by both heads
  ntm_mem_arbiter u_arbiter (
    .CLK            (CLK),
    .RST            (RST),
    .read_req       (read_req),
    .read_req_data  (read_req_data),
    .read_gnt       (read_gnt),
    .write_req      (write_req),
    .write_req_data (write_req_data),
    .write_gnt      (write_gnt),
    .mem_strobe     (mem_strobe),
    .mem_req_data   (mem_req_data),
    .mem_rdata_in   (mem_rdata_raw),
    .mem_rdata      (mem_rdata)
  );

  ntm_memory u_memory (
    .CLK    (CLK),
    .RST    (RST),
    .strobe (mem_strobe),
    .req    (mem_req_data),
    .rdata  (mem_rdata_raw)
  );

endmodule

`default_nettype wire

//--- bench/ntm_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "ntm_params.svh"

module ntm_tb;

  import ntm_pkg::*;

  // Run length and limits in clock cycles
  localparam int num_ops         = 47;
  localparam int op_cycles       = 4 * `NTM_ROWS * `NTM_COLS;
  localparam int watchdog_cycles = num_ops * op_cycles + 100;
  // Contended ops run both heads on one port
  localparam int wait_limit      = 2 * op_cycles;
  // 1.0 in Q8.8
  localparam ntm_word_t one_q88  = 16'sd256;

  // DUT ports
  logic          CLK;
  logic          RST;
  logic          LOAD_ENABLE;
  ntm_load_t     LOAD;
  logic          READ_START;
  logic          READ_READY;
  logic          R_OUT_ENABLE;
  ntm_word_t     R_OUT;
  logic          WRITE_START;
  ntm_write_op_e WRITE_OP;
  logic          WRITE_READY;

  // Shadow memory and copies of the loaded head vectors
  ntm_word_t shadow [`NTM_ROWS][`NTM_COLS];
  ntm_word_t rw     [`NTM_ROWS];
  ntm_word_t ww     [`NTM_ROWS];
  ntm_word_t ev     [`NTM_COLS];
  ntm_word_t av     [`NTM_COLS];

  // Expected read vector with one entry per R_OUT strobe
  ntm_word_t exp_q [$];

  int seed            = 46311;
  int errors          = 0;
  int checks          = 0;
  int r_out_cnt       = 0;
  int read_ready_cnt  = 0;
  int write_ready_cnt = 0;

  ntm_top dut (
    .CLK          (CLK),
    .RST          (RST),
    .LOAD_ENABLE  (LOAD_ENABLE),
    .LOAD         (LOAD),
    .READ_START   (READ_START),
    .READ_READY   (READ_READY),
    .R_OUT_ENABLE (R_OUT_ENABLE),
    .R_OUT        (R_OUT),
    .WRITE_START  (WRITE_START),
    .WRITE_OP     (WRITE_OP),
    .WRITE_READY  (WRITE_READY)
  );

  // 8 ns clock
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Full 32-bit product shifted arithmetically and cut to 16 bits
  function automatic ntm_word_t q88_mul(input ntm_word_t a, input ntm_word_t b);
    int p;
    p = int'(a) * int'(b);
    return ntm_word_t'(p >>> `NTM_FRAC);
  endfunction

  // New value of one memory word for a write opcode
  function automatic ntm_word_t ntm_ref(input ntm_write_op_e op, input ntm_word_t m,
                                        input ntm_word_t w, input ntm_word_t e,
                                        input ntm_word_t a);
    ntm_word_t erased;
    ntm_word_t added;
    ntm_word_t result;
    erased = q88_mul(m, one_q88 - q88_mul(w, e));
    added  = q88_mul(w, a);
    case (op)
      OP_ERASE: result = erased;
      OP_ADD:   result = m + added;
      default:  result = erased + added;
    endcase
    return result;
  endfunction

  // r(k) with sums wrapping at 16 bits
  function automatic ntm_word_t column_sum(input int k);
    ntm_word_t sum;
    sum = '0;
    for (int j = 0; j < `NTM_ROWS; j++) begin
      sum = sum + q88_mul(rw[j], shadow[j][k]);
    end
    return sum;
  endfunction

  function automatic void update_shadow(input ntm_write_op_e op);
    for (int j = 0; j < `NTM_ROWS; j++) begin
      for (int k = 0; k < `NTM_COLS; k++) begin
        shadow[j][k] = ntm_ref(op, shadow[j][k], ww[j], ev[k], av[k]);
      end
    end
  endfunction

  // Small signed value in the open range -limit..limit
  function automatic ntm_word_t rand_word(input int limit);
    int r;
    r = $random(seed) % limit;
    return ntm_word_t'(r);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare and monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input int got, input int expected);
    checks++;
    if (got != expected) begin
      errors++;
      $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  // Sampled mid-cycle away from the drive edge
  always @(negedge CLK) begin
    if (R_OUT_ENABLE) begin
      if (exp_q.size() > 0) begin
        check_value($sformatf("read word %0d", r_out_cnt), int'(R_OUT),
                    int'(exp_q.pop_front()));
      end
      r_out_cnt++;
    end
    if (READ_READY) begin
      read_ready_cnt++;
    end
    if (WRITE_READY) begin
      write_ready_cnt++;
    end
  end

  // Backstop for a hung head
  initial begin
    repeat (watchdog_cycles) @(posedge CLK);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_word(input ntm_vec_sel_e sel, input int idx, input ntm_word_t data);
    @(posedge CLK);
    LOAD_ENABLE <= 1'b1;
    LOAD        <= '{sel: sel, index: `NTM_ROW_W'(idx), data: data};
  endtask

  task automatic end_load();
    @(posedge CLK);
    LOAD_ENABLE <= 1'b0;
  endtask

  task automatic load_read_weights();
    for (int j = 0; j < `NTM_ROWS; j++) begin
      load_word(VEC_READ_WEIGHT, j, rw[j]);
    end
    end_load();
  endtask

  task automatic load_write_vectors();
    for (int j = 0; j < `NTM_ROWS; j++) begin
      load_word(VEC_WRITE_WEIGHT, j, ww[j]);
    end
    for (int k = 0; k < `NTM_COLS; k++) begin
      load_word(VEC_ERASE, k, ev[k]);
      load_word(VEC_ADD, k, av[k]);
    end
    end_load();
  endtask

  // A zero limit leaves that vector all zero
  task automatic fill_write_vectors(input int w_lim, input int e_lim, input int a_lim);
    for (int j = 0; j < `NTM_ROWS; j++) begin
      ww[j] = (w_lim == 0) ? ntm_word_t'(0) : rand_word(w_lim);
    end
    for (int k = 0; k < `NTM_COLS; k++) begin
      ev[k] = (e_lim == 0) ? ntm_word_t'(0) : rand_word(e_lim);
      av[k] = (a_lim == 0) ? ntm_word_t'(0) : rand_word(a_lim);
    end
  endtask

  // Pulse the starts and wait for ready before counting pulses and strobes
  task automatic start_ops(input bit do_read, input bit do_write, input ntm_write_op_e op);
    int rd0;
    int wr0;
    int waited;
    rd0       = read_ready_cnt;
    wr0       = write_ready_cnt;
    r_out_cnt = 0;
    @(posedge CLK);
    READ_START  <= do_read;
    WRITE_START <= do_write;
    WRITE_OP    <= op;
    @(posedge CLK);
    READ_START  <= 1'b0;
    WRITE_START <= 1'b0;
    waited = 0;
    while (((do_read && read_ready_cnt == rd0) || (do_write && write_ready_cnt == wr0))
           && waited < wait_limit) begin
      @(posedge CLK);
      waited++;
    end
    if ((do_read && read_ready_cnt == rd0) || (do_write && write_ready_cnt == wr0)) begin
      errors++;
      $display("timeout at %0t ns: a head gave no ready pulse within %0d cycles",
               $time, wait_limit);
    end
    // Room for a stray second pulse
    repeat (2) @(posedge CLK);
    if (do_read) begin
      check_value("read ready pulses", read_ready_cnt - rd0, 1);
      check_value("read output strobes", r_out_cnt, `NTM_COLS);
    end
    if (do_write) begin
      check_value("write ready pulses", write_ready_cnt - wr0, 1);
    end
  endtask

  task automatic run_write(input ntm_write_op_e op);
    load_write_vectors();
    start_ops(1'b0, 1'b1, op);
    update_shadow(op);
  endtask

  task automatic run_read();
    load_read_weights();
    exp_q.delete();
    for (int k = 0; k < `NTM_COLS; k++) begin
      exp_q.push_back(column_sum(k));
    end
    start_ops(1'b1, 1'b0, OP_ADD);
  endtask

  // One-hot weighting returns row j as is
  task automatic read_row(input int j);
    for (int i = 0; i < `NTM_ROWS; i++) begin
      rw[i] = (i == j) ? one_q88 : ntm_word_t'(0);
    end
    run_read();
  endtask

  task automatic read_all_rows();
    for (int j = 0; j < `NTM_ROWS; j++) begin
      read_row(j);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    RST         <= 1'b1;
    LOAD_ENABLE <= 1'b0;
    LOAD        <= '0;
    READ_START  <= 1'b0;
    WRITE_START <= 1'b0;
    WRITE_OP    <= OP_ADD;
    for (int j = 0; j < `NTM_ROWS; j++) begin
      for (int k = 0; k < `NTM_COLS; k++) begin
        shadow[j][k] = '0;
      end
    end
    repeat (2) @(posedge CLK);
    RST <= 1'b0;

    // Fresh memory reads back as zero
    read_row(3);

    // Single add checked row by row
    fill_write_vectors(128, 0, 512);
    run_write(OP_ADD);
    read_all_rows();

    // Adds accumulate
    fill_write_vectors(128, 0, 512);
    run_write(OP_ADD);
    fill_write_vectors(128, 0, 512);
    run_write(OP_ADD);
    read_all_rows();

    // Full erase of row 2 with its neighbour untouched
    fill_write_vectors(0, 0, 0);
    ww[2] = one_q88;
    for (int k = 0; k < `NTM_COLS; k++) begin
      ev[k] = one_q88;
    end
    run_write(OP_ERASE);
    read_row(2);
    read_row(1);

    // Partial erase scales row 5
    fill_write_vectors(0, 0, 0);
    ww[5] = one_q88;
    ev[0] = 16'sd128;
    ev[1] = 16'sd64;
    ev[2] = 16'sd192;
    ev[3] = 16'sd0;
    run_write(OP_ERASE);
    read_row(5);

    // Erase then add on every word
    fill_write_vectors(128, 256, 512);
    run_write(OP_ERASE_ADD);
    read_all_rows();

    // Weighted sum over all rows
    for (int j = 0; j < `NTM_ROWS; j++) begin
      rw[j] = rand_word(128);
    end
    run_read();

    // Large words and unit weights make column sums wrap
    fill_write_vectors(0, 0, 0);
    for (int j = 0; j < `NTM_ROWS; j++) begin
      ww[j] = one_q88;
      rw[j] = one_q88;
    end
    for (int k = 0; k < `NTM_COLS; k++) begin
      av[k] = 16'sh3000 + rand_word(256);
    end
    run_write(OP_ADD);
    run_read();

    // Both heads started together with read values left unchecked
    fill_write_vectors(128, 256, 512);
    for (int j = 0; j < `NTM_ROWS; j++) begin
      rw[j] = rand_word(128);
    end
    load_write_vectors();
    load_read_weights();
    exp_q.delete();
    start_ops(1'b1, 1'b1, OP_ERASE_ADD);
    update_shadow(OP_ERASE_ADD);
    read_all_rows();

    repeat (4) @(posedge CLK);
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/ntm_pkg.sv
hdl/ntm_head_vectors.sv
hdl/ntm_read_head.sv
hdl/ntm_write_head.sv
hdl/ntm_mem_arbiter.sv
hdl/ntm_memory.sv
hdl/ntm_top.sv
bench/ntm_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the NTM memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ntm_tb -f sim.f \
    -o ntm_sim > build.log 2>&1 \
  && ./obj_dir/ntm_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
echo "simulation clean"
exit 0
